// File: mem_req_arbiter.sv
//////////////////////////////////////////////////
// memory request arbiter
// vector > scalar > ifetch, scalar lane formatting
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "mem_subsys_defs.svh"

module mem_req_arbiter (
    input  logic                          instr_req_i,
    input  logic [`ADDR_W-1:0]            instr_addr_i,
    output logic                          instr_gnt_o,

    input  logic                          sdata_req_i,
    input  logic [`ADDR_W-1:0]            sdata_addr_i,
    input  logic                          sdata_we_i,
    input  logic [`WORD_W/8-1:0]          sdata_be_i,
    input  logic [`WORD_W-1:0]            sdata_wdata_i,
    output logic                          sdata_gnt_o,

    input  logic                          vdata_req_i,
    input  logic [`ADDR_W-1:0]            vdata_addr_i,
    input  logic                          vdata_we_i,
    input  logic [`MEM_BE_W-1:0]          vdata_be_i,
    input  logic [`MEM_W-1:0]             vdata_wdata_i,
    input  logic [`VID_W-1:0]             vdata_id_i,
    output logic                          vdata_gnt_o,

    input  logic                          vect_pending_store_i,
    input  logic                          q_full_i,

    output logic                          mem_req_o,
    output logic [`ADDR_W-1:0]            mem_addr_o,
    output logic                          mem_we_o,
    output logic [`MEM_BE_W-1:0]          mem_be_o,
    output logic [`MEM_W-1:0]             mem_wdata_o,

    output logic                          push_o,
    output mem_subsys_pkg::src_entry_t    push_entry_o
);

    localparam int unsigned LANE_LSB  = $clog2(`WORD_W / 8); // byte offset bits in a word
    localparam int unsigned NUM_LANES = `MEM_W / `WORD_W;

    logic               sdata_hold;
    logic               sdata_sel;
    logic               any_req;
    logic [`LANE_W-1:0] sdata_lane;

    // scalar traffic waits behind vector requests and pending vector stores
    assign sdata_hold = vdata_req_i | vect_pending_store_i;
    assign sdata_sel  = sdata_req_i & ~sdata_hold;
    assign sdata_lane = sdata_addr_i[LANE_LSB +: `LANE_W];

    //////////////////////////////////////////////////
    // grants

    assign any_req     = vdata_req_i | sdata_sel | instr_req_i;
    assign vdata_gnt_o = vdata_req_i & ~q_full_i;
    assign sdata_gnt_o = sdata_sel & ~q_full_i;
    assign instr_gnt_o = instr_req_i & ~vdata_req_i & ~sdata_sel & ~q_full_i;

    assign mem_req_o = any_req & ~q_full_i; // a full queue stops everything
    assign push_o    = mem_req_o;

    //////////////////////////////////////////////////
    // bus formatting

    always_comb begin
        // defaults describe an instruction fetch
        mem_addr_o = instr_addr_i;
        mem_we_o   = 1'b0;
        mem_be_o   = '1;
        for (int i = 0; i < NUM_LANES; i++) begin
            mem_wdata_o[i*`WORD_W +: `WORD_W] = sdata_wdata_i; // scalar word on every lane
        end
        push_entry_o.src  = mem_subsys_pkg::SRC_IFETCH;
        push_entry_o.lane = instr_addr_i[LANE_LSB +: `LANE_W];
        push_entry_o.vid  = '0;

        if (vdata_req_i) begin
            mem_addr_o        = vdata_addr_i;
            mem_we_o          = vdata_we_i;
            mem_be_o          = vdata_be_i;
            mem_wdata_o       = vdata_wdata_i;
            push_entry_o.src  = mem_subsys_pkg::SRC_VECTOR;
            push_entry_o.lane = '0; // full bus returned
            push_entry_o.vid  = vdata_id_i;
        end else if (sdata_sel) begin
            mem_addr_o        = sdata_addr_i;
            mem_we_o          = sdata_we_i;
            mem_be_o          = `MEM_BE_W'(sdata_be_i) << (sdata_lane * (`WORD_W / 8));
            push_entry_o.src  = mem_subsys_pkg::SRC_SCALAR;
            push_entry_o.lane = sdata_lane;
        end
    end

endmodule

// File: mem_resp_router.sv
//////////////////////////////////////////////////
// memory response router
// steers each response to the port at queue head
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "mem_subsys_defs.svh"

module mem_resp_router (
    input  logic                          mem_rvalid_i,
    input  logic                          mem_err_i,
    input  logic [`MEM_W-1:0]             mem_rdata_i,
    input  mem_subsys_pkg::src_entry_t    head_i,

    output logic                          instr_rvalid_o,
    output logic [`WORD_W-1:0]            instr_rdata_o,
    output logic                          instr_err_o,

    output logic                          sdata_rvalid_o,
    output logic [`WORD_W-1:0]            sdata_rdata_o,
    output logic                          sdata_err_o,

    output logic                          vdata_rvalid_o,
    output logic [`MEM_W-1:0]             vdata_rdata_o,
    output logic [`VID_W-1:0]             vdata_id_o,
    output logic                          vdata_err_o
);

    logic [`WORD_W-1:0] lane_word;

    // word lane recorded at grant time
    assign lane_word = mem_rdata_i[head_i.lane * `WORD_W +: `WORD_W];

    assign instr_rvalid_o = mem_rvalid_i & (head_i.src == mem_subsys_pkg::SRC_IFETCH);
    assign sdata_rvalid_o = mem_rvalid_i & (head_i.src == mem_subsys_pkg::SRC_SCALAR);
    assign vdata_rvalid_o = mem_rvalid_i & (head_i.src == mem_subsys_pkg::SRC_VECTOR);

    assign instr_rdata_o = lane_word;
    assign sdata_rdata_o = lane_word;
    assign vdata_rdata_o = mem_rdata_i; // whole bus
    assign vdata_id_o    = head_i.vid;

    // error only reaches the port being answered
    assign instr_err_o = mem_err_i & instr_rvalid_o;
    assign sdata_err_o = mem_err_i & sdata_rvalid_o;
    assign vdata_err_o = mem_err_i & vdata_rvalid_o;

endmodule

// File: mem_subsys.f
+incdir+.
mem_subsys_pkg.sv
mem_req_arbiter.sv
req_source_queue.sv
mem_resp_router.sv
mem_subsys.sv
mem_subsys_assert.sv
tb_mem_subsys.sv

// File: mem_subsys.sv
//////////////////////////////////////////////////
// memory subsystem top
// three requesters sharing one 64-bit memory bus
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "mem_subsys_defs.svh"

module mem_subsys (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    // instruction fetch port
    input  logic                   instr_req_i,
    input  logic [`ADDR_W-1:0]     instr_addr_i,
    output logic                   instr_gnt_o,
    output logic                   instr_rvalid_o,
    output logic [`WORD_W-1:0]     instr_rdata_o,
    output logic                   instr_err_o,

    // scalar data port
    input  logic                   sdata_req_i,
    input  logic [`ADDR_W-1:0]     sdata_addr_i,
    input  logic                   sdata_we_i,
    input  logic [`WORD_W/8-1:0]   sdata_be_i,
    input  logic [`WORD_W-1:0]     sdata_wdata_i,
    output logic                   sdata_gnt_o,
    output logic                   sdata_rvalid_o,
    output logic [`WORD_W-1:0]     sdata_rdata_o,
    output logic                   sdata_err_o,

    // vector data port
    input  logic                   vdata_req_i,
    input  logic [`ADDR_W-1:0]     vdata_addr_i,
    input  logic                   vdata_we_i,
    input  logic [`MEM_BE_W-1:0]   vdata_be_i,
    input  logic [`MEM_W-1:0]      vdata_wdata_i,
    input  logic [`VID_W-1:0]      vdata_id_i,
    output logic                   vdata_gnt_o,
    output logic                   vdata_rvalid_o,
    output logic [`MEM_W-1:0]      vdata_rdata_o,
    output logic [`VID_W-1:0]      vdata_id_o,
    output logic                   vdata_err_o,

    input  logic                   vect_pending_store_i,

    // memory bus
    output logic                   mem_req_o,
    output logic [`ADDR_W-1:0]     mem_addr_o,
    output logic                   mem_we_o,
    output logic [`MEM_BE_W-1:0]   mem_be_o,
    output logic [`MEM_W-1:0]      mem_wdata_o,
    input  logic                   mem_rvalid_i,
    input  logic                   mem_err_i,
    input  logic [`MEM_W-1:0]      mem_rdata_i
);

    logic                       src_push;
    mem_subsys_pkg::src_entry_t src_push_entry;
    mem_subsys_pkg::src_entry_t src_head;
    logic                       src_q_full;
    logic                       src_q_empty; // observed by the bound checks

    mem_req_arbiter mem_req_arbiter_i (
        .instr_req_i          ( instr_req_i          ),
        .instr_addr_i         ( instr_addr_i         ),
        .instr_gnt_o          ( instr_gnt_o          ),
        .sdata_req_i          ( sdata_req_i          ),
        .sdata_addr_i         ( sdata_addr_i         ),
        .sdata_we_i           ( sdata_we_i           ),
        .sdata_be_i           ( sdata_be_i           ),
        .sdata_wdata_i        ( sdata_wdata_i        ),
        .sdata_gnt_o          ( sdata_gnt_o          ),
        .vdata_req_i          ( vdata_req_i          ),
        .vdata_addr_i         ( vdata_addr_i         ),
        .vdata_we_i           ( vdata_we_i           ),
        .vdata_be_i           ( vdata_be_i           ),
        .vdata_wdata_i        ( vdata_wdata_i        ),
        .vdata_id_i           ( vdata_id_i           ),
        .vdata_gnt_o          ( vdata_gnt_o          ),
        .vect_pending_store_i ( vect_pending_store_i ),
        .q_full_i             ( src_q_full           ),
        .mem_req_o            ( mem_req_o            ),
        .mem_addr_o           ( mem_addr_o           ),
        .mem_we_o             ( mem_we_o             ),
        .mem_be_o             ( mem_be_o             ),
        .mem_wdata_o          ( mem_wdata_o          ),
        .push_o               ( src_push             ),
        .push_entry_o         ( src_push_entry       )
    );

    // one entry per granted request, popped by its response
    req_source_queue req_source_queue_i (
        .clk_i        ( clk_i          ),
        .rst_ni       ( rst_ni         ),
        .push_i       ( src_push       ),
        .push_entry_i ( src_push_entry ),
        .pop_i        ( mem_rvalid_i   ),
        .head_o       ( src_head       ),
        .full_o       ( src_q_full     ),
        .empty_o      ( src_q_empty    )
    );

    mem_resp_router mem_resp_router_i (
        .mem_rvalid_i   ( mem_rvalid_i   ),
        .mem_err_i      ( mem_err_i      ),
        .mem_rdata_i    ( mem_rdata_i    ),
        .head_i         ( src_head       ),
        .instr_rvalid_o ( instr_rvalid_o ),
        .instr_rdata_o  ( instr_rdata_o  ),
        .instr_err_o    ( instr_err_o    ),
        .sdata_rvalid_o ( sdata_rvalid_o ),
        .sdata_rdata_o  ( sdata_rdata_o  ),
        .sdata_err_o    ( sdata_err_o    ),
        .vdata_rvalid_o ( vdata_rvalid_o ),
        .vdata_rdata_o  ( vdata_rdata_o  ),
        .vdata_id_o     ( vdata_id_o     ),
        .vdata_err_o    ( vdata_err_o    )
    );

endmodule

// File: mem_subsys_assert.sv
//////////////////////////////////////////////////
// memory subsystem protocol checks
// grant, response and source queue rules
//////////////////////////////////////////////////

`timescale 1ns/10ps

module mem_subsys_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic instr_gnt_i,
    input logic sdata_gnt_i,
    input logic vdata_gnt_i,
    input logic instr_rvalid_i,
    input logic sdata_rvalid_i,
    input logic vdata_rvalid_i,
    input logic mem_rvalid_i,
    input logic src_q_empty_i,
    input logic src_q_full_i,
    input logic src_push_i
);

    // one winner per cycle
    one_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({instr_gnt_i, sdata_gnt_i, vdata_gnt_i}))
        else $error("more than one grant in a cycle");

    one_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({instr_rvalid_i, sdata_rvalid_i, vdata_rvalid_i}))
        else $error("more than one response in a cycle");

    // every response needs a request in flight
    no_stray_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rvalid_i |-> !src_q_empty_i)
        else $error("memory response with no request in flight");

    no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        src_q_full_i |-> !src_push_i)
        else $error("source queue pushed while full");

endmodule

bind mem_subsys mem_subsys_assert mem_subsys_assert_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .instr_gnt_i    ( instr_gnt_o    ),
    .sdata_gnt_i    ( sdata_gnt_o    ),
    .vdata_gnt_i    ( vdata_gnt_o    ),
    .instr_rvalid_i ( instr_rvalid_o ),
    .sdata_rvalid_i ( sdata_rvalid_o ),
    .vdata_rvalid_i ( vdata_rvalid_o ),
    .mem_rvalid_i   ( mem_rvalid_i   ),
    .src_q_empty_i  ( src_q_empty    ),
    .src_q_full_i   ( src_q_full     ),
    .src_push_i     ( src_push       )
);

// File: mem_subsys_defs.svh
//////////////////////////////////////////////////
// memory subsystem widths and sizes
// shared by the arbiter, source queue and router
//////////////////////////////////////////////////

`ifndef MEM_SUBSYS_DEFS_SVH
`define MEM_SUBSYS_DEFS_SVH

`define ADDR_W       32 // byte address
`define WORD_W       32 // instruction and scalar word
`define MEM_W        64 // memory bus
`define MEM_BE_W     8  // one enable per bus byte
`define LANE_W       1  // address bits picking a word lane, above the byte offset
`define VID_W        3  // vector request id

// requests allowed in flight before grants stop
`define SRC_Q_DEPTH  8

`endif

// File: mem_subsys_pkg.sv
//////////////////////////////////////////////////
// memory subsystem types
// request source and in-flight queue entry
//////////////////////////////////////////////////

`include "mem_subsys_defs.svh"

package mem_subsys_pkg;

    // port that issued a memory request
    typedef enum logic [1:0] {
        SRC_IFETCH = 2'd0,
        SRC_SCALAR = 2'd1,
        SRC_VECTOR = 2'd2
    } req_src_e;

    // one in-flight request, kept until its response returns
    typedef struct packed {
        req_src_e            src;
        logic [`LANE_W-1:0]  lane; // word lane for 32-bit ports
        logic [`VID_W-1:0]   vid;  // vector id, zero for other sources
    } src_entry_t;

endpackage

// File: req_source_queue.sv
//////////////////////////////////////////////////
// in-flight request source FIFO
// keeps memory responses matched to their ports
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "mem_subsys_defs.svh"

module req_source_queue (
    input  logic                          clk_i,
    input  logic                          rst_ni,

    input  logic                          push_i,
    input  mem_subsys_pkg::src_entry_t    push_entry_i,
    input  logic                          pop_i,

    output mem_subsys_pkg::src_entry_t    head_o,
    output logic                          full_o,
    output logic                          empty_o
);

    localparam int unsigned PTR_W = $clog2(`SRC_Q_DEPTH);
    localparam int unsigned CNT_W = $clog2(`SRC_Q_DEPTH + 1);

    mem_subsys_pkg::src_entry_t entries [`SRC_Q_DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_en;
    logic             pop_en;

    assign full_o  = (count_q == CNT_W'(`SRC_Q_DEPTH));
    assign empty_o = (count_q == '0);

    assign push_en = push_i & ~full_o;
    assign pop_en  = pop_i & ~empty_o; // a stray response does not underflow

    assign head_o = entries[rd_ptr_q];

    // entry storage
    always_ff @(posedge clk_i) begin
        if (push_en) begin
            entries[wr_ptr_q] <= push_entry_i;
        end
    end

    //////////////////////////////////////////////////
    // pointers and count

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(`SRC_Q_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_en) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(`SRC_Q_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_en && !pop_en) begin
                count_q <= count_q + 1'b1;
            end else if (pop_en && !push_en) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert \
    -f mem_subsys.f \
    --top-module tb_mem_subsys \
    -Mdir obj_dir -o sim_mem_subsys
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_mem_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tb_mem_subsys.sv
//////////////////////////////////////////////////
// memory subsystem testbench
// memory model, directed tests per port
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "mem_subsys_defs.svh"

module tb_mem_subsys;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                  clk_i, rst_ni;
    logic                  instr_req_i, instr_gnt_o, instr_rvalid_o, instr_err_o;
    logic [`ADDR_W-1:0]    instr_addr_i;
    logic [`WORD_W-1:0]    instr_rdata_o;
    logic                  sdata_req_i, sdata_we_i, sdata_gnt_o, sdata_rvalid_o, sdata_err_o;
    logic [`ADDR_W-1:0]    sdata_addr_i;
    logic [`WORD_W/8-1:0]  sdata_be_i;
    logic [`WORD_W-1:0]    sdata_wdata_i, sdata_rdata_o;
    logic                  vdata_req_i, vdata_we_i, vdata_gnt_o, vdata_rvalid_o, vdata_err_o;
    logic [`ADDR_W-1:0]    vdata_addr_i;
    logic [`MEM_BE_W-1:0]  vdata_be_i;
    logic [`MEM_W-1:0]     vdata_wdata_i, vdata_rdata_o;
    logic [`VID_W-1:0]     vdata_id_i, vdata_id_o;
    logic                  vect_pending_store_i;
    logic                  mem_req_o, mem_we_o, mem_rvalid_i, mem_err_i;
    logic [`ADDR_W-1:0]    mem_addr_o;
    logic [`MEM_BE_W-1:0]  mem_be_o;
    logic [`MEM_W-1:0]     mem_wdata_o, mem_rdata_i;

    logic [7:0]          mem_bytes [256];
    logic [`MEM_W-1:0]   pend_data [$];
    logic                pend_err [$];
    int                  pend_due [$];
    int                  delay_tab [32]; // extra reply delays of 0 to 2 cycles, used in turn
    int                  delay_idx;
    logic [7:0]          mem_base;
    logic [`MEM_W-1:0]   mem_line;
    logic                withhold;
    int                  cycle_cnt;
    int                  error_count;

    // response log in arrival order with source 0 for ifetch, 1 for scalar and 2 for vector
    int                  log_src [$];
    logic [`MEM_W-1:0]   log_data [$];
    logic [`VID_W-1:0]   log_id [$];
    logic [2:0]          log_err [$]; // err outputs seen with each response, bit 0 ifetch
    int                  gnt_log [$];

    mem_subsys mem_subsys_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        return (a[7:0] * 8'd13) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5c;
    endfunction

    function automatic logic [63:0] line_at(input logic [31:0] addr);
        logic [63:0] line;
        for (int b = 0; b < 8; b++) begin
            line[8*b +: 8] = fill_byte({addr[31:3], 3'b000} + 32'(b));
        end
        return line;
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        logic [63:0] line;
        line = line_at(addr);
        return addr[2] ? line[63:32] : line[31:0];
    endfunction

    // lines 0xd0 to 0xdf answer with a bus error
    function automatic logic bus_fault(input logic [31:0] addr);
        return addr[7:4] == 4'hd;
    endfunction

    //////////////////////////////////////////////////
    // in-order memory model replying after 1..3 cycles

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_rvalid_i <= 1'b0;
            mem_rdata_i  <= '0;
            mem_err_i    <= 1'b0;
        end else begin
            mem_rvalid_i <= 1'b0;
            mem_err_i    <= 1'b0;
            if (pend_data.size() > 0 && !withhold && cycle_cnt >= pend_due[0]) begin
                mem_rvalid_i <= 1'b1;
                mem_rdata_i  <= pend_data.pop_front();
                mem_err_i    <= pend_err.pop_front();
                void'(pend_due.pop_front());
            end
            if (mem_req_o) begin
                mem_base = {mem_addr_o[7:3], 3'b000};
                for (int b = 0; b < 8; b++) begin
                    mem_line[8*b +: 8] = mem_bytes[mem_base + 8'(b)];
                    if (mem_we_o && mem_be_o[b]) begin
                        mem_bytes[mem_base + 8'(b)] = mem_wdata_o[8*b +: 8];
                    end
                end
                pend_data.push_back(mem_line);
                pend_err.push_back(bus_fault(mem_addr_o));
                pend_due.push_back(cycle_cnt + 1 + delay_tab[delay_idx]);
                delay_idx = (delay_idx + 1) % 32;
            end
        end
    end

    // response and grant monitor
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (instr_rvalid_o) begin
                log_src.push_back(0);
                log_data.push_back({32'h0, instr_rdata_o});
                log_id.push_back('0);
                log_err.push_back({vdata_err_o, sdata_err_o, instr_err_o});
            end
            if (sdata_rvalid_o) begin
                log_src.push_back(1);
                log_data.push_back({32'h0, sdata_rdata_o});
                log_id.push_back('0);
                log_err.push_back({vdata_err_o, sdata_err_o, instr_err_o});
            end
            if (vdata_rvalid_o) begin
                log_src.push_back(2);
                log_data.push_back(vdata_rdata_o);
                log_id.push_back(vdata_id_o);
                log_err.push_back({vdata_err_o, sdata_err_o, instr_err_o});
            end
            if (vdata_gnt_o) gnt_log.push_back(2);
            if (sdata_gnt_o) gnt_log.push_back(1);
            if (instr_gnt_o) gnt_log.push_back(0);
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: no progress after %0d cycles", cycle_cnt);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // port drivers and checks

    task automatic ifetch_req(input logic [31:0] addr);
        @(posedge clk_i);
        instr_req_i  <= 1'b1;
        instr_addr_i <= addr;
        do @(posedge clk_i); while (!instr_gnt_o);
        instr_req_i <= 1'b0;
    endtask

    task automatic scalar_req(input logic [31:0] addr, input logic we, input logic [3:0] be,
                              input logic [31:0] wdata);
        @(posedge clk_i);
        sdata_req_i   <= 1'b1;
        sdata_addr_i  <= addr;
        sdata_we_i    <= we;
        sdata_be_i    <= be;
        sdata_wdata_i <= wdata;
        do @(posedge clk_i); while (!sdata_gnt_o);
        sdata_req_i <= 1'b0;
    endtask

    task automatic vector_req(input logic [31:0] addr, input logic we, input logic [7:0] be,
                              input logic [63:0] wdata, input logic [2:0] id);
        @(posedge clk_i);
        vdata_req_i   <= 1'b1;
        vdata_addr_i  <= addr;
        vdata_we_i    <= we;
        vdata_be_i    <= be;
        vdata_wdata_i <= wdata;
        vdata_id_i    <= id;
        do @(posedge clk_i); while (!vdata_gnt_o);
        vdata_req_i <= 1'b0;
    endtask

    task automatic wait_resps(input int n);
        while (log_src.size() < n) @(posedge clk_i);
    endtask

    task automatic clear_logs();
        log_src.delete();
        log_data.delete();
        log_id.delete();
        log_err.delete();
        gnt_log.delete();
    endtask

    task automatic check_val(input string test, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: expected %h, actual %h", test, exp, act);
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests

    task automatic ifetch_lanes();
        clear_logs();
        ifetch_req(32'h40);
        ifetch_req(32'h44);
        wait_resps(2);
        check_val("ifetch lane0 src", 64'(0), 64'(log_src[0]));
        check_val("ifetch lane0 data", {32'h0, word_at(32'h40)}, log_data[0]);
        check_val("ifetch lane1 src", 64'(0), 64'(log_src[1]));
        check_val("ifetch lane1 data", {32'h0, word_at(32'h44)}, log_data[1]);
    endtask

    task automatic scalar_write_read();
        logic [63:0] line;
        clear_logs();
        scalar_req(32'h4c, 1'b1, 4'hf, 32'hcafe_1234);
        wait_resps(1);
        check_val("scalar write src", 64'(1), 64'(log_src[0]));
        for (int b = 0; b < 8; b++) begin
            line[8*b +: 8] = mem_bytes[8'h48 + 8'(b)];
        end
        check_val("scalar write line", {32'hcafe_1234, word_at(32'h48)}, line);
        scalar_req(32'h4c, 1'b0, 4'hf, 32'h0);
        wait_resps(2);
        check_val("scalar read data", 64'h0000_0000_cafe_1234, log_data[1]);
    endtask

    task automatic vector_write_read();
        clear_logs();
        vector_req(32'h80, 1'b1, 8'hff, 64'h0123_4567_89ab_cdef, 3'd3);
        wait_resps(1);
        check_val("vector write src", 64'(2), 64'(log_src[0]));
        check_val("vector write id", 64'(3), 64'(log_id[0]));
        vector_req(32'h80, 1'b0, 8'hff, 64'h0, 3'd5);
        wait_resps(2);
        check_val("vector read data", 64'h0123_4567_89ab_cdef, log_data[1]);
        check_val("vector read id", 64'(5), 64'(log_id[1]));
    endtask

    task automatic grant_priority();
        clear_logs();
        fork
            ifetch_req(32'h10);
            scalar_req(32'h18, 1'b0, 4'hf, 32'h0);
            vector_req(32'h20, 1'b0, 8'hff, 64'h0, 3'd1);
        join
        wait_resps(3);
        for (int i = 0; i < 3; i++) begin
            check_val("priority grant order", 64'(2 - i), 64'(gnt_log[i]));
            check_val("priority resp order", 64'(2 - i), 64'(log_src[i]));
        end
        check_val("priority vector data", line_at(32'h20), log_data[0]);
        check_val("priority scalar data", {32'h0, word_at(32'h18)}, log_data[1]);
        check_val("priority ifetch data", {32'h0, word_at(32'h10)}, log_data[2]);
        // scalar hold behind a pending vector store
        clear_logs();
        @(posedge clk_i);
        vect_pending_store_i <= 1'b1;
        sdata_req_i  <= 1'b1;
        sdata_addr_i <= 32'h28;
        sdata_we_i   <= 1'b0;
        sdata_be_i   <= 4'hf;
        repeat (5) begin
            @(posedge clk_i);
            assert (!sdata_gnt_o) else begin
                $display("hold test: scalar port granted while a vector store is pending");
                error_count++;
            end
        end
        vect_pending_store_i <= 1'b0;
        do @(posedge clk_i); while (!sdata_gnt_o);
        sdata_req_i <= 1'b0;
        wait_resps(1);
        check_val("hold scalar data", {32'h0, word_at(32'h28)}, log_data[0]);
    endtask

    task automatic queue_backpressure();
        logic [31:0] addr;
        int          port;
        logic [2:0]  exp_err;
        clear_logs();
        withhold <= 1'b1;
        for (int i = 0; i < 10; i++) begin
            addr = 32'hc0 + 32'(i * 4);
            port = (i + 1) % 3;
            if (i == 8) begin
                @(posedge clk_i);
                instr_req_i  <= 1'b1;
                instr_addr_i <= addr;
                repeat (4) begin
                    @(posedge clk_i);
                    assert (!(instr_gnt_o | sdata_gnt_o | vdata_gnt_o)) else begin
                        $display("backpressure test: grant given with the queue full");
                        error_count++;
                    end
                end
                withhold <= 1'b0;
                do @(posedge clk_i); while (!instr_gnt_o);
                instr_req_i <= 1'b0;
            end else if (port == 0) begin
                ifetch_req(addr);
            end else if (port == 1) begin
                scalar_req(addr, 1'b0, 4'hf, 32'h0);
            end else begin
                vector_req(addr, 1'b0, 8'hff, 64'h0, 3'(i));
            end
        end
        wait_resps(10);
        for (int i = 0; i < 10; i++) begin
            addr = 32'hc0 + 32'(i * 4);
            port = (i + 1) % 3;
            exp_err = bus_fault(addr) ? 3'(1 << port) : 3'b000;
            check_val("backpressure src", 64'(port), 64'(log_src[i]));
            check_val("backpressure err", 64'(exp_err), 64'(log_err[i]));
            if (port == 2) begin
                check_val("backpressure vector data", line_at(addr), log_data[i]);
                check_val("backpressure vector id", 64'(i), 64'(log_id[i]));
            end else begin
                check_val("backpressure word data", {32'h0, word_at(addr)}, log_data[i]);
            end
        end
    endtask

    initial begin
        void'($urandom(32'he2b8_1295));
        for (int i = 0; i < 32; i++) begin
            delay_tab[i] = int'($urandom_range(2, 0));
        end
        delay_idx    = 0;
        error_count  = 0;
        cycle_cnt    = 0;
        withhold     = 1'b0;
        rst_ni       = 1'b0;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        sdata_req_i  = 1'b0;
        sdata_addr_i = '0;
        sdata_we_i   = 1'b0;
        sdata_be_i   = '0;
        sdata_wdata_i = '0;
        vdata_req_i  = 1'b0;
        vdata_addr_i = '0;
        vdata_we_i   = 1'b0;
        vdata_be_i   = '0;
        vdata_wdata_i = '0;
        vdata_id_i   = '0;
        vect_pending_store_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        mem_err_i    = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem_bytes[i] = fill_byte(32'(i));
        end
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);

        ifetch_lanes();
        scalar_write_read();
        vector_write_read();
        grant_priority();
        queue_backpressure();

        repeat (2) @(posedge clk_i);
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
